// ==== common/riscv_consts.svh ====
/* RV32I integer cluster constants.
 * Opcodes, function fields, ALU function codes and issue queue sizing.
 */
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Major opcodes
`define OP_OP           7'b0110011
`define OP_OP_IMM       7'b0010011
`define OP_LUI          7'b0110111
`define OP_AUIPC        7'b0010111
`define OP_JAL          7'b1101111
`define OP_JALR         7'b1100111

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// The funct3 codes are shared by OP and OP-IMM.
`define FUNCT3_ADD      3'b000
`define FUNCT3_SLL      3'b001
`define FUNCT3_SLT      3'b010
`define FUNCT3_SLTU     3'b011
`define FUNCT3_XOR      3'b100
`define FUNCT3_SR       3'b101
`define FUNCT3_OR       3'b110
`define FUNCT3_AND      3'b111
`define FUNCT3_JALR     3'b000

`define FUNCT7_BASE     7'b0000000
`define FUNCT7_ALT      7'b0100000

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU function codes
`define ALU_FUNC_W      4
`define ALU_OP_ADD      4'd0
`define ALU_OP_SUB      4'd1
`define ALU_OP_SLL      4'd2
`define ALU_OP_SLT      4'd3
`define ALU_OP_SLTU     4'd4
`define ALU_OP_XOR      4'd5
`define ALU_OP_SRL      4'd6
`define ALU_OP_SRA      4'd7
`define ALU_OP_OR       4'd8
`define ALU_OP_AND      4'd9
`define ALU_OP_PASS_B   4'd10

// Queue entries and initial credits, a power of two.
`define ISSUE_DEPTH     4

`endif

// ==== common/riscv_isa_pkg.sv ====
/* RV32I instruction word types.
 * One 32-bit word seen through its R, I and U formats.
 */
`default_nettype none

package riscv_isa_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_u_t;

    // The decoder picks whichever view fits the opcode.
    typedef union packed {
        inst_r_t r_fmt;
        inst_i_t i_fmt;
        inst_u_t u_fmt;
    } inst_t;

endpackage

`default_nettype wire

// ==== arith/alu.sv ====
/* Integer ALU.
 * Combinational 32-bit datapath selected by a 4-bit function code.
 */
`default_nettype none
`include "riscv_consts.svh"

module alu (
    input  wire [31:0]            alu_op1_i,
    input  wire [31:0]            alu_op2_i,
    input  wire [`ALU_FUNC_W-1:0] alu_func_i,
    output logic [31:0]           alu_out_o
);
    logic [4:0] shift;

    assign shift = alu_op2_i[4:0];

    always_comb begin
        case (alu_func_i)
            `ALU_OP_ADD:    alu_out_o = alu_op1_i + alu_op2_i;
            `ALU_OP_SUB:    alu_out_o = alu_op1_i - alu_op2_i;
            `ALU_OP_SLL:    alu_out_o = alu_op1_i << shift;
            `ALU_OP_SLT: begin
                alu_out_o = {31'b0, $signed(alu_op1_i) < $signed(alu_op2_i)};
            end
            `ALU_OP_SLTU: begin
                alu_out_o = {31'b0, alu_op1_i < alu_op2_i};
            end
            `ALU_OP_XOR:    alu_out_o = alu_op1_i ^ alu_op2_i;
            `ALU_OP_SRL:    alu_out_o = alu_op1_i >> shift;
            // Arithmetic shift keeps the sign bit.
            `ALU_OP_SRA:    alu_out_o = $unsigned($signed(alu_op1_i) >>> shift);
            `ALU_OP_OR:     alu_out_o = alu_op1_i | alu_op2_i;
            `ALU_OP_AND:    alu_out_o = alu_op1_i & alu_op2_i;
            `ALU_OP_PASS_B: alu_out_o = alu_op2_i;
            default:        alu_out_o = 32'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== arith/arith_unit.sv ====
/* Arithmetic unit.
 * Decodes the queue head, drives the ALU, holds one writeback slot
 * and returns a credit for every entry it pops.
 */
`default_nettype none
`include "riscv_consts.svh"

module arith_unit (
    input  wire                   clk_i,
    input  wire                   rst_i,
    input  wire                   q_nonempty_i,
    input  wire riscv_isa_pkg::inst_t q_inst_i,
    input  wire [31:0]            q_pc_i,
    input  wire [31:0]            q_rs1_i,
    input  wire [31:0]            q_rs2_i,
    output logic                  pop_o,
    output logic                  credit_return_o,
    output logic                  wb_valid_o,
    output logic [31:0]           wb_value_o,
    output logic [4:0]            wb_rd_o,
    output logic                  wb_illegal_o,
    input  wire                   wb_ready_i
);
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  shamt;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic        f7_base;
    logic        f7_alt;

    logic [31:0]            alu_op1;
    logic [31:0]            alu_op2;
    logic [`ALU_FUNC_W-1:0] alu_func;
    logic [31:0]            alu_out;
    logic                   illegal;

    assign opcode  = q_inst_i.r_fmt.opcode;
    assign funct3  = q_inst_i.r_fmt.funct3;
    assign funct7  = q_inst_i.r_fmt.funct7;
    assign shamt   = q_inst_i.r_fmt.rs2;
    assign imm_i   = {{20{q_inst_i.i_fmt.imm12[11]}}, q_inst_i.i_fmt.imm12};
    assign imm_u   = {q_inst_i.u_fmt.imm20, 12'b0};
    assign f7_base = (funct7 == `FUNCT7_BASE);
    assign f7_alt  = (funct7 == `FUNCT7_ALT);

    alu alu_i (
        .alu_op1_i  (alu_op1),
        .alu_op2_i  (alu_op2),
        .alu_func_i (alu_func),
        .alu_out_o  (alu_out)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand and function select.
    always_comb begin
        alu_op1  = q_rs1_i;
        alu_op2  = q_rs2_i;
        alu_func = `ALU_OP_ADD;
        illegal  = 1'b0;
        case (opcode)
            `OP_OP: begin
                case (funct3)
                    `FUNCT3_ADD:  alu_func = f7_alt ? `ALU_OP_SUB : `ALU_OP_ADD;
                    `FUNCT3_SLL:  alu_func = `ALU_OP_SLL;
                    `FUNCT3_SLT:  alu_func = `ALU_OP_SLT;
                    `FUNCT3_SLTU: alu_func = `ALU_OP_SLTU;
                    `FUNCT3_XOR:  alu_func = `ALU_OP_XOR;
                    `FUNCT3_SR:   alu_func = f7_alt ? `ALU_OP_SRA : `ALU_OP_SRL;
                    `FUNCT3_OR:   alu_func = `ALU_OP_OR;
                    default:      alu_func = `ALU_OP_AND;
                endcase
                if (funct3 == `FUNCT3_SLL || funct3 == `FUNCT3_SR) begin
                    alu_op2 = {27'b0, q_rs2_i[4:0]};
                end
                // Only ADD/SUB and SRL/SRA have an alternate funct7.
                illegal = !(f7_base ||
                            (f7_alt && (funct3 == `FUNCT3_ADD || funct3 == `FUNCT3_SR)));
            end
            `OP_OP_IMM: begin
                alu_op2 = imm_i;
                case (funct3)
                    `FUNCT3_ADD:  alu_func = `ALU_OP_ADD;
                    `FUNCT3_SLL:  alu_func = `ALU_OP_SLL;
                    `FUNCT3_SLT:  alu_func = `ALU_OP_SLT;
                    `FUNCT3_SLTU: alu_func = `ALU_OP_SLTU;
                    `FUNCT3_XOR:  alu_func = `ALU_OP_XOR;
                    `FUNCT3_SR:   alu_func = f7_alt ? `ALU_OP_SRA : `ALU_OP_SRL;
                    `FUNCT3_OR:   alu_func = `ALU_OP_OR;
                    default:      alu_func = `ALU_OP_AND;
                endcase
                if (funct3 == `FUNCT3_SLL) begin
                    alu_op2 = {27'b0, shamt};
                    illegal = !f7_base;
                end else if (funct3 == `FUNCT3_SR) begin
                    alu_op2 = {27'b0, shamt};
                    illegal = !(f7_base || f7_alt);
                end
            end
            `OP_LUI: begin
                alu_op2  = imm_u;
                alu_func = `ALU_OP_PASS_B;
            end
            `OP_AUIPC: begin
                alu_op1 = q_pc_i;
                alu_op2 = imm_u;
            end
            `OP_JAL: begin
                alu_op1 = q_pc_i;
                alu_op2 = 32'd4;
            end
            `OP_JALR: begin
                alu_op1 = q_pc_i;
                alu_op2 = 32'd4;
                illegal = (funct3 != `FUNCT3_JALR);
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Writeback slot.
    assign pop_o           = q_nonempty_i && (!wb_valid_o || wb_ready_i);
    assign credit_return_o = pop_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
        end else if (pop_o) begin
            wb_valid_o <= 1'b1;
        end else if (wb_ready_i) begin
            wb_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            wb_value_o   <= illegal ? 32'b0 : alu_out;
            wb_rd_o      <= q_inst_i.u_fmt.rd;
            wb_illegal_o <= illegal;
        end
    end

    stall_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_value_o));

endmodule

`default_nettype wire

// ==== verilog/issue_stage.sv ====
/* Issue stage.
 * Accepts instructions while credits remain and pushes them into the queue.
 */
`default_nettype none
`include "riscv_consts.svh"

module issue_stage (
    input  wire                   clk_i,
    input  wire                   rst_i,
    input  wire                   issue_valid_i,
    input  wire riscv_isa_pkg::inst_t issue_inst_i,
    input  wire [31:0]            issue_pc_i,
    input  wire [31:0]            issue_rs1_i,
    input  wire [31:0]            issue_rs2_i,
    output logic                  issue_ready_o,
    input  wire                   credit_return_i,
    output logic                  push_o,
    output riscv_isa_pkg::inst_t  push_inst_o,
    output logic [31:0]           push_pc_o,
    output logic [31:0]           push_rs1_o,
    output logic [31:0]           push_rs2_o
);
    localparam int CNT_W = $clog2(`ISSUE_DEPTH) + 1;

    logic [CNT_W-1:0] credit_cnt;

    assign issue_ready_o = (credit_cnt != '0);
    assign push_o        = issue_valid_i && issue_ready_o;
    assign push_inst_o   = issue_inst_i;
    assign push_pc_o     = issue_pc_i;
    assign push_rs1_o    = issue_rs1_i;
    assign push_rs2_o    = issue_rs2_i;

    // A push and a returned credit in the same cycle cancel out.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credit_cnt <= CNT_W'(`ISSUE_DEPTH);
        end else if (push_o && !credit_return_i) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!push_o && credit_return_i) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    // Credits come back only for entries that were pushed earlier.
    credit_bound_a: assert property (@(posedge clk_i) disable iff (rst_i)
        credit_cnt <= CNT_W'(`ISSUE_DEPTH));

endmodule

`default_nettype wire

// ==== verilog/issue_fifo.sv ====
/* Issue queue.
 * Circular buffer of issued instructions and operands, head shown at the output.
 */
`default_nettype none
`include "riscv_consts.svh"

module issue_fifo (
    input  wire                   clk_i,
    input  wire                   rst_i,
    input  wire                   push_i,
    input  wire riscv_isa_pkg::inst_t push_inst_i,
    input  wire [31:0]            push_pc_i,
    input  wire [31:0]            push_rs1_i,
    input  wire [31:0]            push_rs2_i,
    input  wire                   pop_i,
    output logic                  nonempty_o,
    output riscv_isa_pkg::inst_t  head_inst_o,
    output logic [31:0]           head_pc_o,
    output logic [31:0]           head_rs1_o,
    output logic [31:0]           head_rs2_o
);
    import riscv_isa_pkg::*;

    localparam int PTR_W = $clog2(`ISSUE_DEPTH);

    inst_t       inst_mem [`ISSUE_DEPTH];
    logic [31:0] pc_mem   [`ISSUE_DEPTH];
    logic [31:0] rs1_mem  [`ISSUE_DEPTH];
    logic [31:0] rs2_mem  [`ISSUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    assign nonempty_o  = (count != '0);
    assign head_inst_o = inst_mem[rd_ptr];
    assign head_pc_o   = pc_mem[rd_ptr];
    assign head_rs1_o  = rs1_mem[rd_ptr];
    assign head_rs2_o  = rs2_mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            inst_mem[wr_ptr] <= push_inst_i;
            pc_mem[wr_ptr]   <= push_pc_i;
            rs1_mem[wr_ptr]  <= push_rs1_i;
            rs2_mem[wr_ptr]  <= push_rs2_i;
        end
    end

    // Pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, push_i} - {{PTR_W{1'b0}}, pop_i};
        end
    end

    // The credit loop has to keep the queue from overflowing.
    no_overflow_a: assert property (@(posedge clk_i) disable iff (rst_i)
        push_i |-> (count < (PTR_W+1)'(`ISSUE_DEPTH)) || pop_i);

    no_underflow_a: assert property (@(posedge clk_i) disable iff (rst_i)
        pop_i |-> nonempty_o);

endmodule

`default_nettype wire

// ==== verilog/arith_cluster.sv ====
/* Integer arithmetic cluster.
 * Issue stage, credit-managed queue and arithmetic unit.
 */
`default_nettype none

module arith_cluster (
    input  wire                   clk_i,
    input  wire                   rst_i,
    input  wire                   issue_valid_i,
    input  wire riscv_isa_pkg::inst_t issue_inst_i,
    input  wire [31:0]            issue_pc_i,
    input  wire [31:0]            issue_rs1_i,
    input  wire [31:0]            issue_rs2_i,
    output logic                  issue_ready_o,
    output logic                  wb_valid_o,
    output logic [31:0]           wb_value_o,
    output logic [4:0]            wb_rd_o,
    output logic                  wb_illegal_o,
    input  wire                   wb_ready_i
);
    import riscv_isa_pkg::*;

    logic        push;
    inst_t       push_inst;
    logic [31:0] push_pc;
    logic [31:0] push_rs1;
    logic [31:0] push_rs2;
    logic        q_nonempty;
    inst_t       head_inst;
    logic [31:0] head_pc;
    logic [31:0] head_rs1;
    logic [31:0] head_rs2;
    logic        pop;
    logic        credit_return;

    issue_stage issue_stage_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .issue_valid_i   (issue_valid_i),
        .issue_inst_i    (issue_inst_i),
        .issue_pc_i      (issue_pc_i),
        .issue_rs1_i     (issue_rs1_i),
        .issue_rs2_i     (issue_rs2_i),
        .issue_ready_o   (issue_ready_o),
        .credit_return_i (credit_return),
        .push_o          (push),
        .push_inst_o     (push_inst),
        .push_pc_o       (push_pc),
        .push_rs1_o      (push_rs1),
        .push_rs2_o      (push_rs2)
    );

    issue_fifo issue_fifo_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (push),
        .push_inst_i (push_inst),
        .push_pc_i   (push_pc),
        .push_rs1_i  (push_rs1),
        .push_rs2_i  (push_rs2),
        .pop_i       (pop),
        .nonempty_o  (q_nonempty),
        .head_inst_o (head_inst),
        .head_pc_o   (head_pc),
        .head_rs1_o  (head_rs1),
        .head_rs2_o  (head_rs2)
    );

    arith_unit arith_unit_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .q_nonempty_i    (q_nonempty),
        .q_inst_i        (head_inst),
        .q_pc_i          (head_pc),
        .q_rs1_i         (head_rs1),
        .q_rs2_i         (head_rs2),
        .pop_o           (pop),
        .credit_return_o (credit_return),
        .wb_valid_o      (wb_valid_o),
        .wb_value_o      (wb_value_o),
        .wb_rd_o         (wb_rd_o),
        .wb_illegal_o    (wb_illegal_o),
        .wb_ready_i      (wb_ready_i)
    );

endmodule

`default_nettype wire

// ==== verif/arith_tests.svh ====
/* Directed tests for the arithmetic cluster.
 * Each task issues a short stream and waits until it has drained.
 */
`ifndef ARITH_TESTS_SVH
`define ARITH_TESTS_SVH

task automatic check_reset_state();
    @(negedge clk_i);
    compare_flag("wb_valid_o", 1'b0, wb_valid_o);
    compare_flag("issue_ready_o", 1'b1, issue_ready_o);
    @(posedge clk_i);
    #DRIVE_DELAY;
endtask

task automatic reg_reg_ops();
    logic [2:0] f3;
    logic [6:0] f7;
    issue_one(build_r(`FUNCT7_ALT, `FUNCT3_ADD, 5'd1), 32'h0, 32'h0000_0005, 32'h0000_0009);
    issue_one(build_r(`FUNCT7_BASE, `FUNCT3_SLT, 5'd2), 32'h0, 32'hffff_fff0, 32'h0000_0005);
    issue_one(build_r(`FUNCT7_BASE, `FUNCT3_SLTU, 5'd3), 32'h0, 32'hffff_fff0, 32'h0000_0005);
    // Only the low five bits of rs2 give the shift amount.
    issue_one(build_r(`FUNCT7_ALT, `FUNCT3_SR, 5'd4), 32'h0, 32'h8000_1234, 32'hffff_ffe4);
    issue_one(build_r(`FUNCT7_BASE, `FUNCT3_SR, 5'd5), 32'h0, 32'h8000_1234, 32'h0000_0004);
    for (int k = 0; k < 16; k++) begin
        f3 = 3'(rand_bits(3));
        f7 = `FUNCT7_BASE;
        if ((f3 == `FUNCT3_ADD || f3 == `FUNCT3_SR) && rand_bits(1) == 32'd1) begin
            f7 = `FUNCT7_ALT;
        end
        issue_one(build_r(f7, f3, 5'(rand_bits(5))), rand_bits(32), rand_bits(32),
                  rand_bits(32));
    end
    wait_drained();
endtask

task automatic imm_ops();
    logic [2:0]  f3;
    logic [11:0] imm;
    issue_one(build_i(`OP_OP_IMM, `FUNCT3_ADD, 12'hff6, 5'd6), 32'h0, 32'h0000_0100, 32'h0);
    // rs2 is chosen so that comparing against it would flip the result.
    issue_one(build_i(`OP_OP_IMM, `FUNCT3_SLT, 12'hfff, 5'd7), 32'h0, 32'hffff_fffd,
              32'hffff_fff0);
    issue_one(build_i(`OP_OP_IMM, `FUNCT3_SLTU, 12'hfff, 5'd8), 32'h0, 32'h0000_0005, 32'h0);
    issue_one(build_i(`OP_OP_IMM, `FUNCT3_SR, {`FUNCT7_ALT, 5'd8}, 5'd9), 32'h0,
              32'hf000_0000, 32'h0);
    issue_one(build_i(`OP_OP_IMM, `FUNCT3_SR, {`FUNCT7_BASE, 5'd8}, 5'd10), 32'h0,
              32'hf000_0000, 32'h0);
    for (int k = 0; k < 16; k++) begin
        f3  = 3'(rand_bits(3));
        imm = 12'(rand_bits(12));
        if (f3 == `FUNCT3_SLL) begin
            imm[11:5] = `FUNCT7_BASE;
        end else if (f3 == `FUNCT3_SR) begin
            imm[11:5] = imm[11] ? `FUNCT7_ALT : `FUNCT7_BASE;
        end
        issue_one(build_i(`OP_OP_IMM, f3, imm, 5'(rand_bits(5))), rand_bits(32),
                  rand_bits(32), rand_bits(32));
    end
    wait_drained();
endtask

task automatic upper_imm_and_link();
    logic [31:0] pc;
    for (int k = 0; k < 2; k++) begin
        pc = {30'(rand_bits(30)), 2'b00};
        issue_one(build_u(`OP_LUI, 20'(rand_bits(20)), 5'(rand_bits(5))), pc,
                  rand_bits(32), rand_bits(32));
        issue_one(build_u(`OP_AUIPC, 20'(rand_bits(20)), 5'(rand_bits(5))), pc,
                  rand_bits(32), rand_bits(32));
        issue_one(build_u(`OP_JAL, 20'(rand_bits(20)), 5'(rand_bits(5))), pc,
                  rand_bits(32), rand_bits(32));
        issue_one(build_i(`OP_JALR, `FUNCT3_JALR, 12'(rand_bits(12)), 5'(rand_bits(5))), pc,
                  rand_bits(32), rand_bits(32));
    end
    wait_drained();
endtask

// The slot takes one result, then the queue fills behind it.
task automatic backpressure_fill();
    int accepted;
    accepted   = 0;
    wb_ready_i = 1'b0;
    for (int k = 0; k < `ISSUE_DEPTH + 3; k++) begin
        issue_valid_i = 1'b1;
        issue_inst_i  = build_r(`FUNCT7_BASE, `FUNCT3_ADD, 5'(k + 1));
        issue_pc_i    = 32'h0;
        issue_rs1_i   = rand_bits(32);
        issue_rs2_i   = rand_bits(32);
        @(negedge clk_i);
        if (issue_ready_o) begin
            accepted++;
        end
        @(posedge clk_i);
        #DRIVE_DELAY;
    end
    issue_valid_i = 1'b0;
    compare_word("accepted count", 32'(`ISSUE_DEPTH + 1), 32'(accepted));
    @(negedge clk_i);
    compare_flag("issue_ready_o", 1'b0, issue_ready_o);
    @(posedge clk_i);
    #DRIVE_DELAY;
    wb_ready_i = 1'b1;
    wait_drained();
endtask

task automatic illegal_encodings();
    issue_one(build_r(`FUNCT7_BASE, `FUNCT3_ADD, 5'd1), 32'h0, rand_bits(32), rand_bits(32));
    // Load opcode, which the cluster does not handle.
    issue_one(build_u(7'b0000011, 20'h12345, 5'd2), 32'h40, rand_bits(32), rand_bits(32));
    issue_one(build_r(`FUNCT7_BASE, `FUNCT3_XOR, 5'd3), 32'h0, rand_bits(32), rand_bits(32));
    issue_one(build_r(7'b0000001, `FUNCT3_ADD, 5'd4), 32'h0, rand_bits(32), rand_bits(32));
    issue_one(build_r(`FUNCT7_BASE, `FUNCT3_OR, 5'd5), 32'h0, rand_bits(32), rand_bits(32));
    wait_drained();
endtask

`endif

// ==== verif/arith_cluster_tb.sv ====
/* Testbench for the integer arithmetic cluster.
 * Issues directed and LFSR driven instruction streams and checks every
 * writeback against a reference model through a scoreboard queue.
 */
`default_nettype none
`include "riscv_consts.svh"

module arith_cluster_tb;
    import riscv_isa_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int DRIVE_DELAY     = 2;
    localparam int INST_COUNT      = 64;
    localparam int WATCHDOG_CYCLES = INST_COUNT * 40 + 200;

    logic        clk_i;
    logic        rst_i;
    logic        issue_valid_i;
    inst_t       issue_inst_i;
    logic [31:0] issue_pc_i;
    logic [31:0] issue_rs1_i;
    logic [31:0] issue_rs2_i;
    logic        issue_ready_o;
    logic        wb_valid_o;
    logic [31:0] wb_value_o;
    logic [4:0]  wb_rd_o;
    logic        wb_illegal_o;
    logic        wb_ready_i;

    logic [31:0] lfsr_state = 32'h148d;

    // Each entry is {rd, illegal, value}.
    logic [37:0] expect_q[$];
    logic [37:0] exp_entry;

    arith_cluster arith_cluster_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .issue_valid_i (issue_valid_i),
        .issue_inst_i  (issue_inst_i),
        .issue_pc_i    (issue_pc_i),
        .issue_rs1_i   (issue_rs1_i),
        .issue_rs2_i   (issue_rs2_i),
        .issue_ready_o (issue_ready_o),
        .wb_valid_o    (wb_valid_o),
        .wb_value_o    (wb_value_o),
        .wb_rd_o       (wb_rd_o),
        .wb_illegal_o  (wb_illegal_o),
        .wb_ready_i    (wb_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Galois LFSR that steps once for each bit it returns.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = 32'b0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            r = {r[30:0], b};
        end
        return r;
    endfunction

    // Expected {illegal, value} straight from the RV32I rules.
    function automatic logic [32:0] model_result(input inst_t inst, input logic [31:0] pc,
                                                 input logic [31:0] rs1,
                                                 input logic [31:0] rs2);
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] u_imm;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic        is_imm;
        logic        ok;
        r      = 32'b0;
        ok     = 1'b1;
        f7     = inst.r_fmt.funct7;
        f3     = inst.r_fmt.funct3;
        u_imm  = {inst.u_fmt.imm20, 12'b0};
        is_imm = (inst.r_fmt.opcode == `OP_OP_IMM);
        b      = is_imm ? {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12} : rs2;
        case (inst.r_fmt.opcode)
            `OP_OP, `OP_OP_IMM: begin
                case (f3)
                    `FUNCT3_ADD:  r = (!is_imm && f7 == `FUNCT7_ALT) ? rs1 - b : rs1 + b;
                    `FUNCT3_SLL:  r = rs1 << b[4:0];
                    `FUNCT3_SLT:  r = {31'b0, $signed(rs1) < $signed(b)};
                    `FUNCT3_SLTU: r = {31'b0, rs1 < b};
                    `FUNCT3_XOR:  r = rs1 ^ b;
                    `FUNCT3_SR: begin
                        if (f7 == `FUNCT7_ALT) begin
                            r = $signed(rs1) >>> b[4:0];
                        end else begin
                            r = rs1 >> b[4:0];
                        end
                    end
                    `FUNCT3_OR:   r = rs1 | b;
                    default:      r = rs1 & b;
                endcase
                if (!is_imm) begin
                    ok = (f7 == `FUNCT7_BASE) ||
                         (f7 == `FUNCT7_ALT && (f3 == `FUNCT3_ADD || f3 == `FUNCT3_SR));
                end else if (f3 == `FUNCT3_SLL) begin
                    ok = (f7 == `FUNCT7_BASE);
                end else if (f3 == `FUNCT3_SR) begin
                    ok = (f7 == `FUNCT7_BASE) || (f7 == `FUNCT7_ALT);
                end
            end
            `OP_LUI:   r = u_imm;
            `OP_AUIPC: r = pc + u_imm;
            `OP_JAL:   r = pc + 32'd4;
            `OP_JALR: begin
                r  = pc + 32'd4;
                ok = (f3 == `FUNCT3_JALR);
            end
            default:   ok = 1'b0;
        endcase
        return {!ok, ok ? r : 32'b0};
    endfunction

    function automatic inst_t build_r(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] dest);
        inst_t w;
        w.r_fmt = '{funct7: f7, rs2: 5'd2, rs1: 5'd1, funct3: f3, rd: dest, opcode: `OP_OP};
        return w;
    endfunction

    function automatic inst_t build_i(input logic [6:0] op, input logic [2:0] f3,
                                      input logic [11:0] imm, input logic [4:0] dest);
        inst_t w;
        w.i_fmt = '{imm12: imm, rs1: 5'd1, funct3: f3, rd: dest, opcode: op};
        return w;
    endfunction

    function automatic inst_t build_u(input logic [6:0] op, input logic [19:0] imm,
                                      input logic [4:0] dest);
        inst_t w;
        w.u_fmt = '{imm20: imm, rd: dest, opcode: op};
        return w;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic compare_word(input string sig, input logic [31:0] exp,
                                input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR time %0t %s expected %h actual %h", $time, sig, exp, act);
            $display("Test failed");
            $fatal(1, "mismatch on %s", sig);
        end
    endtask

    task automatic compare_flag(input string sig, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR time %0t %s expected %b actual %b", $time, sig, exp, act);
            $display("Test failed");
            $fatal(1, "mismatch on %s", sig);
        end
    endtask

    // Handshakes are sampled at the falling edge, where all inputs and outputs are settled.
    always @(negedge clk_i) begin
        if (!rst_i && issue_valid_i && issue_ready_o) begin
            expect_q.push_back({issue_inst_i.r_fmt.rd,
                                model_result(issue_inst_i, issue_pc_i, issue_rs1_i,
                                             issue_rs2_i)});
        end
        if (!rst_i && wb_valid_o && wb_ready_i) begin
            if (expect_q.size() == 0) begin
                $display("A writeback appeared with no instruction outstanding");
                $display("Test failed");
                $fatal(1, "unexpected writeback");
            end else begin
                exp_entry = expect_q.pop_front();
                compare_word("wb_value_o", exp_entry[31:0], wb_value_o);
                compare_word("wb_rd_o", {27'b0, exp_entry[37:33]}, {27'b0, wb_rd_o});
                compare_flag("wb_illegal_o", exp_entry[32], wb_illegal_o);
            end
        end
    end

    task automatic issue_one(input inst_t inst, input logic [31:0] pc,
                             input logic [31:0] rs1, input logic [31:0] rs2);
        logic taken;
        issue_valid_i = 1'b1;
        issue_inst_i  = inst;
        issue_pc_i    = pc;
        issue_rs1_i   = rs1;
        issue_rs2_i   = rs2;
        taken         = 1'b0;
        while (!taken) begin
            @(negedge clk_i);
            taken = issue_ready_o;
            @(posedge clk_i);
            #DRIVE_DELAY;
        end
        issue_valid_i = 1'b0;
    endtask

    task automatic wait_drained();
        while (expect_q.size() != 0) begin
            @(posedge clk_i);
        end
        #DRIVE_DELAY;
    endtask

    `include "arith_tests.svh"

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the instruction stream finished");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    initial begin
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        issue_inst_i  = '0;
        issue_pc_i    = 32'b0;
        issue_rs1_i   = 32'b0;
        issue_rs2_i   = 32'b0;
        wb_ready_i    = 1'b1;
        repeat (3) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_i = 1'b0;
        check_reset_state();
        reg_reg_ops();
        imm_ops();
        upper_imm_and_link();
        backpressure_fill();
        illegal_encodings();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+common
+incdir+verif
common/riscv_isa_pkg.sv
arith/alu.sv
arith/arith_unit.sv
verilog/issue_stage.sv
verilog/issue_fifo.sv
verilog/arith_cluster.sv
verif/arith_cluster_tb.sv

// ==== Makefile ====
# Verilator build and run for the arithmetic cluster testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= arith_cluster_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test build clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	elif ! grep -q "Test passed" $(LOG); then \
		echo "FAIL: run ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
